// ==== common/rv_pkg.sv ====
/* opcodes, alu operations and the control and pipeline register structs
   shared by the rv_core stages. */
package rv_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic    reg_wr;
    logic    mem_rd;
    logic    mem_wr;
    logic    mem_byte; // lbu / sb size.
    logic    br_eq;
    logic    br_ne;
    logic    jal;
    logic    jalr;
    logic    a_pc;     // pc as operand a.
    logic    b_imm;    // immediate as operand b.
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd;
    logic [31:0] imm;
    ctrl_t       ctrl;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] result;    // alu result or link address.
    logic [31:0] store_val;
    logic [4:0]  rd;
    ctrl_t       ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  // addi x0,x0,0.
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== fetch/rv_fetch.sv ====
/* program counter and if/id instruction register. */
`timescale 1ns/10ps

module rv_fetch #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              stall,
  input  rv_pkg::redirect_t redirect,
  input  logic [31:0]       instr,
  output logic [31:0]       instr_addr,
  output logic [31:0]       if_instr,
  output logic [31:0]       if_pc
);

  logic [31:0] pc;

  assign instr_addr = pc; // memory answers in the same cycle.

  // redirect wins over stall.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= RESET_PC;
      if_instr <= rv_pkg::NOP_INSTR;
    end else if (redirect.valid) begin
      pc       <= redirect.target;
      if_instr <= rv_pkg::NOP_INSTR; // drop the wrong-path fetch.
    end else if (!stall) begin
      pc       <= pc + 32'd4;
      if_instr <= instr;
    end
  end

  // pc of the instruction now held in if_instr.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_pc <= RESET_PC;
    end else if (!redirect.valid && !stall) begin
      if_pc <= pc;
    end
  end

endmodule

// ==== decode/rv_decode.sv ====
/* instruction decode, immediate generation, load-use stall
   detection and the id/ex pipeline register. */
`timescale 1ns/10ps

module rv_decode (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [31:0]       if_instr,
  input  logic [31:0]       if_pc,
  output logic [4:0]        rs1_addr,
  output logic [4:0]        rs2_addr,
  input  logic [31:0]       rs1_val,
  input  logic [31:0]       rs2_val,
  input  rv_pkg::redirect_t redirect,
  output logic              stall,
  output rv_pkg::id_ex_t    id_ex
);

  logic [2:0]      funct3;
  logic [31:0]     imm;
  rv_pkg::ctrl_t   ctrl;
  rv_pkg::alu_op_e arith_op;
  logic            arith_ok;
  logic            dec_valid;
  logic            rs1_used;
  logic            rs2_used;

  assign funct3   = if_instr[14:12];
  assign rs1_addr = if_instr[19:15];
  assign rs2_addr = if_instr[24:20];

  // shared by op and op-imm; sub only exists for op (opcode bit 5).
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000:  arith_op = (if_instr[5] && if_instr[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      3'b111:  arith_op = rv_pkg::ALU_AND;
      default: begin
        arith_op = rv_pkg::ALU_ADD;
        arith_ok = 1'b0; // shifts and sltu not supported.
      end
    endcase
  end

  always_comb begin
    ctrl      = '0;
    imm       = {{20{if_instr[31]}}, if_instr[31:20]}; // i-type.
    dec_valid = 1'b1;
    rs1_used  = 1'b1;
    rs2_used  = 1'b0;
    case (rv_pkg::opcode_e'(if_instr[6:0]))
      rv_pkg::OPC_LUI: begin
        imm         = {if_instr[31:12], 12'b0};
        ctrl.reg_wr = 1'b1;
        ctrl.b_imm  = 1'b1;
        ctrl.alu_op = rv_pkg::ALU_PASS_B;
        rs1_used    = 1'b0;
      end
      rv_pkg::OPC_OP: begin
        ctrl.reg_wr = 1'b1;
        ctrl.alu_op = arith_op;
        dec_valid   = arith_ok;
        rs2_used    = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        ctrl.reg_wr = 1'b1;
        ctrl.b_imm  = 1'b1;
        ctrl.alu_op = arith_op;
        dec_valid   = arith_ok;
      end
      rv_pkg::OPC_LOAD: begin
        ctrl.reg_wr   = 1'b1;
        ctrl.mem_rd   = 1'b1;
        ctrl.b_imm    = 1'b1;
        ctrl.mem_byte = (funct3 == 3'b100);
        dec_valid     = (funct3 == 3'b100) || (funct3 == 3'b010); // lbu, lw.
      end
      rv_pkg::OPC_STORE: begin
        imm           = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
        ctrl.mem_wr   = 1'b1;
        ctrl.b_imm    = 1'b1;
        ctrl.mem_byte = (funct3 == 3'b000);
        dec_valid     = (funct3 == 3'b000) || (funct3 == 3'b010); // sb, sw.
        rs2_used      = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        imm        = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                      if_instr[30:25], if_instr[11:8], 1'b0};
        ctrl.br_eq = (funct3 == 3'b000);
        ctrl.br_ne = (funct3 == 3'b001);
        ctrl.a_pc  = 1'b1; // alu forms pc + imm.
        ctrl.b_imm = 1'b1;
        dec_valid  = (funct3[2:1] == 2'b00);
        rs2_used   = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        imm         = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                       if_instr[20], if_instr[30:21], 1'b0};
        ctrl.reg_wr = 1'b1;
        ctrl.jal    = 1'b1;
        ctrl.a_pc   = 1'b1;
        ctrl.b_imm  = 1'b1;
        rs1_used    = 1'b0;
      end
      rv_pkg::OPC_JALR: begin
        ctrl.reg_wr = 1'b1;
        ctrl.jalr   = 1'b1;
        ctrl.b_imm  = 1'b1;
      end
      default: dec_valid = 1'b0;
    endcase
  end

  // load in ex whose result is needed here next cycle.
  assign stall = id_ex.valid && id_ex.ctrl.mem_rd && (id_ex.rd != 5'd0) &&
                 ((rs1_used && (id_ex.rd == rs1_addr)) ||
                  (rs2_used && (id_ex.rd == rs2_addr)));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (redirect.valid || stall) begin
      id_ex.valid <= 1'b0; // bubble.
    end else begin
      id_ex <= '{valid: dec_valid, pc: if_pc, rs1_val: rs1_val, rs2_val: rs2_val,
                 rs1_addr: rs1_addr, rs2_addr: rs2_addr, rd: if_instr[11:7],
                 imm: imm, ctrl: ctrl};
    end
  end

endmodule

// ==== logic/rv_regfile.sv ====
/* general register file x1..x31 with write-through reads. */
`timescale 1ns/10ps

module rv_regfile (
  input  logic         clk,
  input  logic         arst_n,
  input  logic [4:0]   rs1_addr,
  input  logic [4:0]   rs2_addr,
  output logic [31:0]  rs1_val,
  output logic [31:0]  rs2_val,
  input  rv_pkg::wb_t  wb
);

  logic [31:0] regs [1:31];
  logic        wr_en;

  assign wr_en = wb.valid && (wb.rd != 5'd0); // x0 is never written.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // same-cycle write is seen by the read.
  assign rs1_val = (rs1_addr == 5'd0) ? 32'd0 :
                   (wr_en && (wb.rd == rs1_addr)) ? wb.data : regs[rs1_addr];
  assign rs2_val = (rs2_addr == 5'd0) ? 32'd0 :
                   (wr_en && (wb.rd == rs2_addr)) ? wb.data : regs[rs2_addr];

endmodule

// ==== execute/rv_execute.sv ====
/* operand forwarding, alu, branch and jump resolution
   and the ex/mem pipeline register. */
`timescale 1ns/10ps

module rv_execute (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::id_ex_t    id_ex,
  input  rv_pkg::wb_t       wb,
  output rv_pkg::ex_mem_t   ex_mem,
  output rv_pkg::redirect_t redirect
);

  logic [31:0] fwd_a;
  logic [31:0] fwd_b;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_res;
  logic [31:0] link;
  logic        taken;

  // bypass from mem/wb.
  assign fwd_a = (wb.valid && (wb.rd != 5'd0) && (wb.rd == id_ex.rs1_addr)) ?
                 wb.data : id_ex.rs1_val;
  assign fwd_b = (wb.valid && (wb.rd != 5'd0) && (wb.rd == id_ex.rs2_addr)) ?
                 wb.data : id_ex.rs2_val;

  assign op_a = id_ex.ctrl.a_pc  ? id_ex.pc  : fwd_a;
  assign op_b = id_ex.ctrl.b_imm ? id_ex.imm : fwd_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_PASS_B: alu_res = op_b;
      default:            alu_res = op_a + op_b;
    endcase
  end

  assign link = id_ex.pc + 32'd4;

  // branches compare the register operands, alu gives the target.
  assign taken = (id_ex.ctrl.br_eq && (fwd_a == fwd_b)) ||
                 (id_ex.ctrl.br_ne && (fwd_a != fwd_b)) ||
                 id_ex.ctrl.jal || id_ex.ctrl.jalr;

  assign redirect.valid  = id_ex.valid && taken;
  assign redirect.target = {alu_res[31:1], 1'b0}; // bit 0 cleared for jalr.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid     <= id_ex.valid;
      ex_mem.result    <= (id_ex.ctrl.jal || id_ex.ctrl.jalr) ? link : alu_res;
      ex_mem.store_val <= fwd_b;
      ex_mem.rd        <= id_ex.rd;
      ex_mem.ctrl      <= id_ex.ctrl;
    end
  end

endmodule

// ==== logic/rv_lsu.sv ====
/* store strobes and lane alignment, byte load extraction
   and writeback select. */
`timescale 1ns/10ps

module rv_lsu (
  input  rv_pkg::ex_mem_t ex_mem,
  input  logic [31:0]     data_rdata,
  output logic [31:0]     data_addr,
  output logic [3:0]      data_wr,
  output logic [31:0]     data_wdata,
  output rv_pkg::wb_t     wb
);

  logic [1:0]  byte_sel;
  logic [7:0]  ld_byte;
  logic [31:0] ld_val;

  assign data_addr = ex_mem.result;
  assign byte_sel  = ex_mem.result[1:0];

  always_comb begin
    data_wr    = 4'b0000;
    data_wdata = ex_mem.ctrl.mem_byte ? {4{ex_mem.store_val[7:0]}} : ex_mem.store_val;
    if (ex_mem.valid && ex_mem.ctrl.mem_wr) begin
      data_wr = ex_mem.ctrl.mem_byte ? (4'b0001 << byte_sel) : 4'b1111;
    end
  end

  assign ld_byte = data_rdata[8*byte_sel +: 8];
  assign ld_val  = ex_mem.ctrl.mem_byte ? {24'd0, ld_byte} : data_rdata; // lbu zero-extends.

  assign wb.valid = ex_mem.valid && ex_mem.ctrl.reg_wr;
  assign wb.rd    = ex_mem.rd;
  assign wb.data  = ex_mem.ctrl.mem_rd ? ld_val : ex_mem.result;

endmodule

// ==== logic/rv_core.sv ====
/* rv_core top level, wires fetch, decode, register file,
   execute and load/store unit together. */
`timescale 1ns/10ps

module rv_core #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        arst_n,
  output logic [31:0] instr_addr,
  input  logic [31:0] instr,
  output logic [31:0] data_addr,
  output logic [3:0]  data_wr,
  output logic [31:0] data_wdata,
  input  logic [31:0] data_rdata
);

  logic [31:0]       if_instr;
  logic [31:0]       if_pc;
  logic              stall;
  logic [4:0]        rs1_addr;
  logic [4:0]        rs2_addr;
  logic [31:0]       rs1_val;
  logic [31:0]       rs2_val;
  rv_pkg::redirect_t redirect;
  rv_pkg::id_ex_t    id_ex;
  rv_pkg::ex_mem_t   ex_mem;
  rv_pkg::wb_t       wb;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) i_fetch (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .redirect   (redirect),
    .instr      (instr),
    .instr_addr (instr_addr),
    .if_instr   (if_instr),
    .if_pc      (if_pc)
  );

  rv_decode i_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .if_instr (if_instr),
    .if_pc    (if_pc),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .redirect (redirect),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .wb       (wb)
  );

  rv_execute i_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .id_ex    (id_ex),
    .wb       (wb),
    .ex_mem   (ex_mem),
    .redirect (redirect)
  );

  rv_lsu i_lsu (
    .ex_mem     (ex_mem),
    .data_rdata (data_rdata),
    .data_addr  (data_addr),
    .data_wr    (data_wr),
    .data_wdata (data_wdata),
    .wb         (wb)
  );

endmodule

// ==== tb/tb_rv_core.sv ====
/* rv_core testbench with memory models, instruction encoders,
   a reference instruction-set model and a store checker. */
`timescale 1ns/10ps

module tb_rv_core;

  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  strb;
    logic [31:0] data;
  } store_t;

  localparam logic [31:0] HALT_INSTR = 32'h0000_006f; // jal x0, 0.

  logic        clk;
  logic        arst_n;
  logic [31:0] instr_addr;
  logic [31:0] instr;
  logic [31:0] data_addr;
  logic [3:0]  data_wr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] dmem_init [256];
  logic [31:0] lfsr = 32'hfd73;
  store_t      exp_q [$];
  int          seen = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          prog_len = 0;
  int          cycles = 0;
  int          limit = 100;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .instr      (instr),
    .data_addr  (data_addr),
    .data_wr    (data_wr),
    .data_wdata (data_wdata),
    .data_rdata (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign instr      = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[9:2]];

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic next_random_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], next_random_bit()};
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  function automatic logic [31:0] encode_r(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] opc, input int f3, input int rd,
                                           input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] encode_s(input int f3, input int rs1, input int rs2,
                                           input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] encode_b(input int f3, input int rs1, input int rs2,
                                           input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encode_u(input int rd, input int imm);
    return {imm[19:0], rd[4:0], rv_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] encode_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
  endfunction

  function automatic void emit(input logic [31:0] w);
    imem[prog_len[7:0]] = w;
    prog_len++;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return 32'd0;
    endcase
  endfunction

  // runs imem from address zero up to the halt loop, queueing every store.
  function automatic void run_reference();
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] nxt;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    store_t      st;
    int          steps;
    for (int k = 0; k < 32; k++) begin
      x[k] = '0;
    end
    for (int k = 0; k < 256; k++) begin
      mem[k] = dmem_init[k];
    end
    pc    = '0;
    steps = 0;
    while (steps < 1000) begin
      ins = imem[pc[9:2]];
      if (ins == HALT_INSTR) break;
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      rd    = ins[11:7];
      f3    = ins[14:12];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      nxt   = pc + 32'd4;
      case (ins[6:0])
        rv_pkg::OPC_LUI:    x[rd] = {ins[31:12], 12'd0};
        rv_pkg::OPC_OP:     x[rd] = alu_ref(f3, ins[30], a, b);
        rv_pkg::OPC_OP_IMM: x[rd] = alu_ref(f3, 1'b0, a, imm_i);
        rv_pkg::OPC_LOAD: begin
          addr  = a + imm_i;
          word  = mem[addr[9:2]];
          x[rd] = (f3 == 3'b100) ? ((word >> {addr[1:0], 3'b000}) & 32'h0000_00ff) : word;
        end
        rv_pkg::OPC_STORE: begin
          addr    = a + imm_s;
          st.addr = addr;
          st.strb = (f3 == 3'b000) ? (4'b0001 << addr[1:0]) : 4'b1111;
          st.data = (f3 == 3'b000) ? {4{b[7:0]}} : b;
          mem[addr[9:2]] = merge_word(mem[addr[9:2]], st.data, st.strb);
          exp_q.push_back(st);
        end
        rv_pkg::OPC_BRANCH: begin
          if ((f3 == 3'b000) == (a == b)) nxt = pc + imm_b; // beq or bne taken.
        end
        rv_pkg::OPC_JAL: begin
          x[rd] = pc + 32'd4;
          nxt   = pc + imm_j;
        end
        rv_pkg::OPC_JALR: begin
          nxt   = (a + imm_i) & ~32'd1;
          x[rd] = pc + 32'd4;
        end
        default: ;
      endcase
      x[0] = '0;
      pc   = nxt;
      steps++;
    end
  endfunction

  // data memory follows the byte strobes, reloaded while in reset.
  always @(posedge clk) begin
    if (!arst_n) begin
      for (int k = 0; k < 256; k++) begin
        dmem[k[7:0]] <= dmem_init[k[7:0]];
      end
    end else if (data_wr != 4'b0000) begin
      dmem[data_addr[9:2]] <= merge_word(dmem[data_addr[9:2]], data_wdata, data_wr);
    end
  end

  // store checker.
  always @(posedge clk) begin
    store_t got;
    if (arst_n && (data_wr != 4'b0000)) begin
      got = '{addr: data_addr, strb: data_wr, data: data_wdata};
      assert (seen < exp_q.size()) else begin
        $display("store to %h at %0t ns was not made by the program", data_addr, $time);
        errors++;
      end
      if (seen < exp_q.size()) begin
        checks++;
        assert (got == exp_q[seen]) else begin
          $display("FAIL %0t: store %0d got %h/%b/%h, expected %h/%b/%h", $time, seen,
                   got.addr, got.strb, got.data,
                   exp_q[seen].addr, exp_q[seen].strb, exp_q[seen].data);
          errors++;
        end
      end
      seen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the stores did not all arrive", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic begin_test();
    @(posedge clk);
    arst_n <= 1'b0;
    @(negedge clk);
    exp_q.delete();
    seen     = 0;
    prog_len = 0;
    for (int k = 0; k < 256; k++) begin
      imem[k[7:0]]      = rv_pkg::NOP_INSTR;
      dmem_init[k[7:0]] = random_bits(32);
    end
  endtask

  task automatic finish_test(input string name);
    int err0;
    emit(HALT_INSTR);
    run_reference();
    limit += 4 * prog_len;
    err0   = errors;
    repeat (3) begin
      @(negedge clk);
      assert ((instr_addr == 32'd0) && (data_wr == 4'b0000)) else begin
        $display("FAIL %0t: in reset instr_addr %h data_wr %b", $time, instr_addr, data_wr);
        errors++;
      end
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (instr_addr == 32'd0) else begin
      $display("FAIL %0t: instr_addr %h after reset", $time, instr_addr);
      errors++;
    end
    while (seen < exp_q.size()) @(negedge clk);
    repeat (6) @(negedge clk); // catch stray stores.
    tests++;
    $display("test %s: %0d stores, %0d errors", name, exp_q.size(), errors - err0);
  endtask

  task automatic reset_program();
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 1, 0, random_bits(12)));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 2, 1, 1));
    emit(rv_pkg::NOP_INSTR);
    emit(rv_pkg::NOP_INSTR);
    emit(encode_s(2, 0, 2, 0));
    emit(encode_s(2, 0, 1, 4));
  endtask

  task automatic alu_program();
    int r_f3 [6];
    r_f3 = '{0, 0, 7, 6, 4, 2};
    emit(encode_u(1, random_bits(20)));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 1, 1, random_bits(12)));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 2, 0, random_bits(12)));
    for (int k = 0; k < 6; k++) begin
      emit(encode_r((k == 1) ? 32 : 0, r_f3[k], 3 + k, 2 + k, 1 + k)); // add sub and or xor slt.
      if (k % 2 == 1) emit(encode_s(2, 0, 3 + k, 4 * k));
    end
    for (int k = 0; k < 5; k++) begin
      emit(encode_i(rv_pkg::OPC_OP_IMM, r_f3[k + 1], 9 + k, 8 + k, random_bits(12)));
      emit(encode_s(2, 0, 9 + k, 40 + 4 * k));
    end
    for (int k = 3; k < 14; k++) begin
      emit(encode_s(2, 0, k, 256 + 4 * k));
    end
  endtask

  task automatic load_use_program();
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 1, 0, 8));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 2, 1, 5)); // uses the load at once.
    emit(encode_s(2, 0, 2, 64));
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 3, 0, 12));
    emit(encode_r(0, 0, 4, 3, 3));
    emit(encode_s(2, 0, 4, 68));
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 5, 0, 16));
    emit(encode_s(2, 0, 5, 72)); // store data from the load.
    emit(encode_i(rv_pkg::OPC_LOAD, 4, 6, 0, 17));
    emit(encode_r(0, 4, 7, 1, 6));
    emit(encode_s(2, 0, 7, 76));
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 8, 0, 20));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 7, 8, 8, 1020)); // word address in range.
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 9, 8, 0));
    emit(encode_s(2, 0, 9, 80));
  endtask

  task automatic branch_program();
    emit(encode_u(1, random_bits(20)));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 2, 1, 0));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 3, 1, 1));
    emit(encode_b(0, 1, 2, 12)); // beq taken.
    emit(encode_s(2, 0, 3, 200));
    emit(encode_s(2, 0, 3, 204));
    emit(encode_s(2, 0, 2, 8));
    emit(encode_b(1, 1, 2, 12)); // bne not taken.
    emit(encode_s(2, 0, 3, 12));
    emit(encode_s(2, 0, 3, 16));
    emit(encode_b(1, 1, 3, 12)); // bne taken.
    emit(encode_s(2, 0, 2, 208));
    emit(encode_s(2, 0, 2, 212));
    emit(encode_s(2, 0, 1, 20));
    emit(encode_b(0, 1, 3, 12)); // beq not taken.
    emit(encode_s(2, 0, 1, 24));
    emit(encode_s(2, 0, 2, 28));
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 4, 3, -1));
    emit(encode_b(0, 4, 1, 12)); // compare on a forwarded value.
    emit(encode_s(2, 0, 3, 216));
    emit(encode_s(2, 0, 3, 220));
    emit(encode_s(2, 0, 4, 32));
  endtask

  task automatic jump_program();
    int tgt;
    emit(encode_j(1, 12));
    emit(encode_s(2, 0, 1, 40));
    emit(encode_s(2, 0, 1, 44));
    emit(encode_s(2, 0, 1, 32));
    tgt = 4 * (prog_len + 4);
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 5, 0, tgt + 1)); // odd, bit 0 is dropped.
    emit(encode_i(rv_pkg::OPC_JALR, 0, 6, 5, 0));
    emit(encode_s(2, 0, 6, 40));
    emit(encode_s(2, 0, 6, 44));
    emit(encode_s(2, 0, 6, 36));
    emit(encode_j(7, 8));
    emit(encode_s(2, 0, 7, 44));
    emit(encode_s(2, 0, 7, 48));
    tgt = 4 * (prog_len + 4);
    emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 8, 0, tgt - 16));
    emit(encode_i(rv_pkg::OPC_JALR, 0, 8, 8, 16)); // rd equals rs1.
    emit(encode_s(2, 0, 8, 40));
    emit(encode_s(2, 0, 8, 44));
    emit(encode_s(2, 0, 8, 52));
  endtask

  task automatic byte_program();
    for (int k = 0; k < 4; k++) begin
      emit(encode_i(rv_pkg::OPC_OP_IMM, 0, 1 + k, 0, random_bits(12)));
    end
    for (int k = 0; k < 4; k++) begin
      emit(encode_s(0, 0, 1 + k, 96 + k));
    end
    for (int k = 0; k < 4; k++) begin
      emit(encode_i(rv_pkg::OPC_LOAD, 4, 10 + k, 0, 96 + k));
    end
    for (int k = 0; k < 4; k++) begin
      emit(encode_s(2, 0, 10 + k, 112 + 4 * k));
    end
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 14, 0, 96));
    emit(encode_s(2, 0, 14, 128));
    emit(encode_s(0, 0, 1, 201)); // into a random word.
    emit(encode_i(rv_pkg::OPC_LOAD, 2, 15, 0, 200));
    emit(encode_s(2, 0, 15, 132));
    emit(encode_i(rv_pkg::OPC_LOAD, 4, 16, 0, 203));
    emit(encode_s(0, 0, 16, 138));
  endtask

  initial begin
    arst_n = 1'b0;
    for (int k = 0; k < 256; k++) begin
      imem[k[7:0]]      = rv_pkg::NOP_INSTR;
      dmem_init[k[7:0]] = '0;
    end
    begin_test();
    reset_program();
    finish_test("reset");
    begin_test();
    alu_program();
    finish_test("alu");
    begin_test();
    load_use_program();
    finish_test("load_use");
    begin_test();
    branch_program();
    finish_test("branch");
    begin_test();
    jump_program();
    finish_test("jump");
    begin_test();
    byte_program();
    finish_test("byte");
    $display("tests %0d, stores checked %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
common/rv_pkg.sv
fetch/rv_fetch.sv
decode/rv_decode.sv
logic/rv_regfile.sv
execute/rv_execute.sv
logic/rv_lsu.sv
logic/rv_core.sv
tb/tb_rv_core.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f rv_core.f \
		--top-module tb_rv_core -Mdir obj_dir -o sim_rv_core
	./obj_dir/sim_rv_core | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
